// File: project.f
+incdir+source
source/wbaxil_pkg.sv
source/wbaxil_request.sv
source/wbaxil_tag_fifo.sv
source/wbaxil_response.sv
source/wbaxil_monitor.sv
source/wbaxil_top.sv
verif/axil_slave_model.sv
verif/wbaxil_tb.sv

// File: source/wbaxil_monitor.sv
`include "wbaxil_params.svh"

`default_nettype none
`timescale 1ns/1ps

module wbaxil_monitor
	import wbaxil_pkg::*;
(
	input	wire				i_clk,
	input	wire				i_axi_reset_n,

	// Write address
	input	wire				i_awvalid,
	input	wire				i_awready,
	input	wire axil_addr_t		i_aw,

	// Write data
	input	wire				i_wvalid,
	input	wire				i_wready,
	input	wire axil_wdata_t		i_w,

	// Write response
	input	wire				i_bvalid,
	input	wire				i_bready,
	input	wire axil_resp_e		i_bresp,

	// Read address
	input	wire				i_arvalid,
	input	wire				i_arready,
	input	wire axil_addr_t		i_ar,

	// Read data
	input	wire				i_rvalid,
	input	wire				i_rready,
	input	wire axil_rdata_t		i_r,

	output	logic [`WBAXIL_LGDEPTH-1:0]	o_awr_outstanding,
	output	logic [`WBAXIL_LGDEPTH-1:0]	o_wr_outstanding,
	output	logic [`WBAXIL_LGDEPTH-1:0]	o_rd_outstanding
);

	localparam int LGD = `WBAXIL_LGDEPTH;

	logic	aw_hs;
	logic	w_hs;
	logic	b_hs;
	logic	ar_hs;
	logic	r_hs;

	// Up on request, down on response, hold on both or neither
	function automatic logic [LGD-1:0] step_count(
		input logic [LGD-1:0]	count,
		input logic		inc,
		input logic		dec
	);
		logic [LGD-1:0]	next;
		case ({inc, dec})
		2'b10:	next = count + 1'b1;
		2'b01:	next = count - 1'b1;
		default:	next = count;
		endcase
		return next;
	endfunction

	assign aw_hs = i_awvalid && i_awready;
	assign w_hs  = i_wvalid && i_wready;
	assign b_hs  = i_bvalid && i_bready;
	assign ar_hs = i_arvalid && i_arready;
	assign r_hs  = i_rvalid && i_rready;

	////////////////////////////////////////////////////////////
	// Outstanding counts
	////////////////////////////////////////////////////////////

	// One B retires one AW and one W
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_awr_outstanding <= '0;
			o_wr_outstanding  <= '0;
			o_rd_outstanding  <= '0;
		end
		else
		begin
			o_awr_outstanding <= step_count(o_awr_outstanding, aw_hs, b_hs);
			o_wr_outstanding  <= step_count(o_wr_outstanding, w_hs, b_hs);
			o_rd_outstanding  <= step_count(o_rd_outstanding, ar_hs, r_hs);
		end
	end

	////////////////////////////////////////////////////////////
	// Protocol rules
	////////////////////////////////////////////////////////////

	// Bus idle on the cycle after any reset cycle
	a_reset_idle: assert property (@(posedge i_clk)
		!i_axi_reset_n |=> !i_awvalid && !i_wvalid && !i_arvalid
			&& !i_bvalid && !i_rvalid)
		else $error("valid high right after reset");

	// Valid and payload hold until ready
	a_aw_stable: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		i_awvalid && !i_awready |=> i_awvalid && $stable(i_aw))
		else $error("AW changed while stalled");
	a_w_stable: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		i_wvalid && !i_wready |=> i_wvalid && $stable(i_w))
		else $error("W changed while stalled");
	a_ar_stable: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		i_arvalid && !i_arready |=> i_arvalid && $stable(i_ar))
		else $error("AR changed while stalled");
	a_b_stable: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
		else $error("B changed while stalled");
	a_r_stable: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		i_rvalid && !i_rready |=> i_rvalid && $stable(i_r))
		else $error("R changed while stalled");

	// Tag queue depth keeps every count short of all-ones
	a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		!(&o_awr_outstanding) && !(&o_wr_outstanding) && !(&o_rd_outstanding))
		else $error("outstanding count overflow");

	// No response without a request behind it
	a_b_has_req: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		i_bvalid |-> (aw_hs || o_awr_outstanding != '0)
			&& (w_hs || o_wr_outstanding != '0))
		else $error("write response with nothing outstanding");
	a_r_has_req: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		i_rvalid |-> (ar_hs || o_rd_outstanding != '0))
		else $error("read data with nothing outstanding");

endmodule

`default_nettype wire

// File: source/wbaxil_params.svh
`ifndef WBAXIL_PARAMS_SVH
`define WBAXIL_PARAMS_SVH

`default_nettype none

// Byte address width on both buses
`define WBAXIL_AW	28

// Data bus width in bits
// One strobe or select bit per byte
`define WBAXIL_DW	32

// Width of the monitor outstanding counters
`define WBAXIL_LGDEPTH	4

// Log2 of the order tag queue depth
// Must stay below WBAXIL_LGDEPTH so no count can reach all-ones
`define WBAXIL_LGFIFO	2

`default_nettype wire

`endif

// File: source/wbaxil_pkg.sv
`include "wbaxil_params.svh"

`default_nettype none

package wbaxil_pkg;

	// One pipelined Wishbone request as presented with stb
	typedef struct packed
	{
		logic				we;
		logic [`WBAXIL_AW-1:0]		addr;
		logic [`WBAXIL_DW-1:0]		data;
		logic [`WBAXIL_DW/8-1:0]	sel;
	} wb_req_t;

	// Address beat, same layout for AW and AR
	typedef struct packed
	{
		logic [`WBAXIL_AW-1:0]		addr;
	} axil_addr_t;

	// Write data beat
	typedef struct packed
	{
		logic [`WBAXIL_DW-1:0]		data;
		logic [`WBAXIL_DW/8-1:0]	strb;
	} axil_wdata_t;

	// AXI response codes
	// Bit 1 set means an error of either kind
	typedef enum logic [1:0]
	{
		OKAY	= 2'b00,
		EXOKAY	= 2'b01,
		SLVERR	= 2'b10,
		DECERR	= 2'b11
	} axil_resp_e;

	// Read data beat with its response
	typedef struct packed
	{
		logic [`WBAXIL_DW-1:0]		data;
		axil_resp_e			resp;
	} axil_rdata_t;

	// Which response kind the next retired transaction returns
	typedef struct packed
	{
		logic				is_write;
	} pend_tag_t;

endpackage

`default_nettype wire

// File: source/wbaxil_request.sv
`default_nettype none
`timescale 1ns/1ps

module wbaxil_request
	import wbaxil_pkg::*;
(
	input	wire			i_clk,
	input	wire			i_axi_reset_n,

	// Pipelined Wishbone request side
	input	wire			i_wb_stb,
	input	wire wb_req_t		i_wb_req,
	output	logic			o_wb_stall,

	// AXI-lite write address
	output	logic			o_awvalid,
	input	wire			i_awready,
	output	axil_addr_t		o_aw,

	// AXI-lite write data
	output	logic			o_wvalid,
	input	wire			i_wready,
	output	axil_wdata_t		o_w,

	// AXI-lite read address
	output	logic			o_arvalid,
	input	wire			i_arready,
	output	axil_addr_t		o_ar,

	// Order tag queue
	input	wire			i_fifo_full,
	output	logic			o_push,
	output	pend_tag_t		o_push_tag
);

	logic	aw_wait;
	logic	w_wait;
	logic	ar_wait;
	logic	accept;

	// Beat issued but not yet taken by the slave
	assign aw_wait = o_awvalid && !i_awready;
	assign w_wait  = o_wvalid && !i_wready;
	assign ar_wait = o_arvalid && !i_arready;

	// Hold off Wishbone until every beat is gone and a tag slot is free
	assign o_wb_stall = aw_wait || w_wait || ar_wait || i_fifo_full;
	assign accept     = i_wb_stb && !o_wb_stall;

	// One tag per accepted request, in Wishbone order
	assign o_push     = accept;
	assign o_push_tag = '{is_write: i_wb_req.we};

	////////////////////////////////////////////////////////////
	// Channel valids
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_awvalid <= 1'b0;
			o_wvalid  <= 1'b0;
			o_arvalid <= 1'b0;
		end
		else if (accept)
		begin
			// Write raises AW and W together
			o_awvalid <= i_wb_req.we;
			o_wvalid  <= i_wb_req.we;
			o_arvalid <= !i_wb_req.we;
		end
		else
		begin
			// AW and W may be taken on different cycles
			if (i_awready)
				o_awvalid <= 1'b0;
			if (i_wready)
				o_wvalid <= 1'b0;
			if (i_arready)
				o_arvalid <= 1'b0;
		end
	end

	// Payloads only move on accept, so they hold while waiting
	always_ff @(posedge i_clk)
	begin
		if (accept && i_wb_req.we)
		begin
			o_aw.addr <= i_wb_req.addr;
			o_w.data  <= i_wb_req.data;
			o_w.strb  <= i_wb_req.sel;
		end
		if (accept && !i_wb_req.we)
			o_ar.addr <= i_wb_req.addr;
	end

	// A beat still waiting for ready holds, so no new request replaced it
	a_aw_held: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		aw_wait |=> o_awvalid && $stable(o_aw))
		else $error("request accepted while a write address was pending");
	a_w_held: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		w_wait |=> o_wvalid && $stable(o_w))
		else $error("request accepted while a write data beat was pending");
	a_ar_held: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		ar_wait |=> o_arvalid && $stable(o_ar))
		else $error("request accepted while a read address was pending");

endmodule

`default_nettype wire

// File: source/wbaxil_response.sv
`include "wbaxil_params.svh"

`default_nettype none
`timescale 1ns/1ps

module wbaxil_response
	import wbaxil_pkg::*;
(
	input	wire			i_clk,
	input	wire			i_axi_reset_n,

	// Head of the order tag queue
	input	wire pend_tag_t		i_head,
	input	wire			i_empty,
	output	logic			o_pop,

	// AXI-lite write response
	input	wire			i_bvalid,
	output	logic			o_bready,
	input	wire axil_resp_e	i_bresp,

	// AXI-lite read data
	input	wire			i_rvalid,
	output	logic			o_rready,
	input	wire axil_rdata_t	i_r,

	// Wishbone return side
	output	logic			o_wb_ack,
	output	logic			o_wb_err,
	output	logic [`WBAXIL_DW-1:0]	o_wb_data
);

	logic	b_done;
	logic	r_done;

	////////////////////////////////////////////////////////////
	// In-order channel selection
	////////////////////////////////////////////////////////////

	// Only the channel the oldest request expects is opened
	// A response for a younger request waits on its valid
	assign o_bready = !i_empty && i_head.is_write;
	assign o_rready = !i_empty && !i_head.is_write;

	assign b_done = i_bvalid && o_bready;
	assign r_done = i_rvalid && o_rready;

	// Retire the head tag on either handshake
	assign o_pop = b_done || r_done;

	////////////////////////////////////////////////////////////
	// Wishbone return
	////////////////////////////////////////////////////////////

	// Single cycle pulse after the handshake
	// SLVERR and DECERR both have bit 1 set
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_wb_ack <= 1'b0;
			o_wb_err <= 1'b0;
		end
		else
		begin
			o_wb_ack <= (b_done && !i_bresp[1]) || (r_done && !i_r.resp[1]);
			o_wb_err <= (b_done && i_bresp[1]) || (r_done && i_r.resp[1]);
		end
	end

	// Read data rides along with the pulse
	always_ff @(posedge i_clk)
	begin
		if (r_done)
			o_wb_data <= i_r.data;
	end

	// Ack and err never on the same cycle
	a_one_return: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		!(o_wb_ack && o_wb_err))
		else $error("ack and err high together");

endmodule

`default_nettype wire

// File: source/wbaxil_tag_fifo.sv
`include "wbaxil_params.svh"

`default_nettype none
`timescale 1ns/1ps

module wbaxil_tag_fifo
	import wbaxil_pkg::*;
(
	input	wire			i_clk,
	input	wire			i_axi_reset_n,

	// Push side from the issuer
	input	wire			i_push,
	input	wire pend_tag_t		i_tag,

	// Pop side from the collector
	input	wire			i_pop,
	output	pend_tag_t		o_head,

	output	logic			o_empty,
	output	logic			o_full
);

	localparam int LG    = `WBAXIL_LGFIFO;
	localparam int DEPTH = 1 << LG;

	// Extra pointer bit tells full from empty
	pend_tag_t		mem [DEPTH];
	logic [LG:0]		wr_ptr;
	logic [LG:0]		rd_ptr;

	// Tag storage
	always_ff @(posedge i_clk)
	begin
		if (i_push && !o_full)
			mem[wr_ptr[LG-1:0]] <= i_tag;
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (i_push && !o_full)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop && !o_empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full  = (wr_ptr[LG] != rd_ptr[LG])
		&& (wr_ptr[LG-1:0] == rd_ptr[LG-1:0]);

	// Oldest tag, valid only while not empty
	assign o_head = mem[rd_ptr[LG-1:0]];

	////////////////////////////////////////////////////////////
	// Queue rules
	////////////////////////////////////////////////////////////

	// Issuer must stall on full
	a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		i_push |-> !o_full)
		else $error("tag pushed into a full queue");

	// Collector opens no channel while empty
	a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		i_pop |-> !o_empty)
		else $error("tag popped from an empty queue");

	// One cycle from push to head
	a_push_to_head: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(i_push && o_empty) |=> !o_empty && (o_head == $past(i_tag)))
		else $error("pushed tag not at head one cycle later");

endmodule

`default_nettype wire

// File: source/wbaxil_top.sv
`include "wbaxil_params.svh"

`default_nettype none
`timescale 1ns/1ps

module wbaxil_top
	import wbaxil_pkg::*;
(
	input	wire				i_clk,
	input	wire				i_axi_reset_n,

	// Pipelined Wishbone slave port
	input	wire				i_wb_cyc,
	input	wire				i_wb_stb,
	input	wire wb_req_t			i_wb_req,
	output	wire				o_wb_stall,
	output	wire				o_wb_ack,
	output	wire				o_wb_err,
	output	wire [`WBAXIL_DW-1:0]		o_wb_data,

	// AXI-lite master port
	output	wire				o_axi_awvalid,
	input	wire				i_axi_awready,
	output	wire axil_addr_t		o_axi_aw,
	output	wire				o_axi_wvalid,
	input	wire				i_axi_wready,
	output	wire axil_wdata_t		o_axi_w,
	input	wire				i_axi_bvalid,
	output	wire				o_axi_bready,
	input	wire axil_resp_e		i_axi_bresp,
	output	wire				o_axi_arvalid,
	input	wire				i_axi_arready,
	output	wire axil_addr_t		o_axi_ar,
	input	wire				i_axi_rvalid,
	output	wire				o_axi_rready,
	input	wire axil_rdata_t		i_axi_r,

	// Monitor counts
	output	wire [`WBAXIL_LGDEPTH-1:0]	o_awr_outstanding,
	output	wire [`WBAXIL_LGDEPTH-1:0]	o_wr_outstanding,
	output	wire [`WBAXIL_LGDEPTH-1:0]	o_rd_outstanding
);

	// Order tag path from issuer through queue to collector
	wire			push;
	wire pend_tag_t		push_tag;
	wire pend_tag_t		head;
	wire			tag_empty;
	wire			tag_full;
	wire			pop;

	// Strobe only counts inside a bus cycle
	wbaxil_request u_request (
		.i_clk		(i_clk),
		.i_axi_reset_n	(i_axi_reset_n),
		.i_wb_stb	(i_wb_cyc && i_wb_stb),
		.i_wb_req	(i_wb_req),
		.o_wb_stall	(o_wb_stall),
		.o_awvalid	(o_axi_awvalid),
		.i_awready	(i_axi_awready),
		.o_aw		(o_axi_aw),
		.o_wvalid	(o_axi_wvalid),
		.i_wready	(i_axi_wready),
		.o_w		(o_axi_w),
		.o_arvalid	(o_axi_arvalid),
		.i_arready	(i_axi_arready),
		.o_ar		(o_axi_ar),
		.i_fifo_full	(tag_full),
		.o_push		(push),
		.o_push_tag	(push_tag)
	);

	wbaxil_tag_fifo u_tag_fifo (
		.i_clk		(i_clk),
		.i_axi_reset_n	(i_axi_reset_n),
		.i_push		(push),
		.i_tag		(push_tag),
		.i_pop		(pop),
		.o_head		(head),
		.o_empty	(tag_empty),
		.o_full		(tag_full)
	);

	wbaxil_response u_response (
		.i_clk		(i_clk),
		.i_axi_reset_n	(i_axi_reset_n),
		.i_head		(head),
		.i_empty	(tag_empty),
		.o_pop		(pop),
		.i_bvalid	(i_axi_bvalid),
		.o_bready	(o_axi_bready),
		.i_bresp	(i_axi_bresp),
		.i_rvalid	(i_axi_rvalid),
		.o_rready	(o_axi_rready),
		.i_r		(i_axi_r),
		.o_wb_ack	(o_wb_ack),
		.o_wb_err	(o_wb_err),
		.o_wb_data	(o_wb_data)
	);

	// Passive watcher on the five AXI channels
	wbaxil_monitor u_monitor (
		.i_clk			(i_clk),
		.i_axi_reset_n		(i_axi_reset_n),
		.i_awvalid		(o_axi_awvalid),
		.i_awready		(i_axi_awready),
		.i_aw			(o_axi_aw),
		.i_wvalid		(o_axi_wvalid),
		.i_wready		(i_axi_wready),
		.i_w			(o_axi_w),
		.i_bvalid		(i_axi_bvalid),
		.i_bready		(o_axi_bready),
		.i_bresp		(i_axi_bresp),
		.i_arvalid		(o_axi_arvalid),
		.i_arready		(i_axi_arready),
		.i_ar			(o_axi_ar),
		.i_rvalid		(i_axi_rvalid),
		.i_rready		(o_axi_rready),
		.i_r			(i_axi_r),
		.o_awr_outstanding	(o_awr_outstanding),
		.o_wr_outstanding	(o_wr_outstanding),
		.o_rd_outstanding	(o_rd_outstanding)
	);

endmodule

`default_nettype wire

// File: verif/axil_slave_model.sv
`include "wbaxil_params.svh"

`default_nettype none
`timescale 1ns/1ps

module axil_slave_model
	import wbaxil_pkg::*;
(
	input	wire			i_clk,
	input	wire			i_axi_reset_n,

	// Test controls, 0 means always ready
	input	wire [3:0]		i_max_delay,
	input	wire			i_hold,

	input	wire			i_awvalid,
	output	logic			o_awready,
	input	wire axil_addr_t	i_aw,
	input	wire			i_wvalid,
	output	logic			o_wready,
	input	wire axil_wdata_t	i_w,
	output	logic			o_bvalid,
	input	wire			i_bready,
	output	axil_resp_e		o_bresp,
	input	wire			i_arvalid,
	output	logic			o_arready,
	input	wire axil_addr_t	i_ar,
	output	logic			o_rvalid,
	input	wire			i_rready,
	output	axil_rdata_t		o_r
);

	// Word-addressed storage, unwritten words read the fill pattern
	logic [`WBAXIL_DW-1:0]	mem [logic [`WBAXIL_AW-3:0]];
	logic [`WBAXIL_AW-1:0]	aw_q [$];
	axil_wdata_t		w_q [$];
	axil_resp_e		b_q [$];
	axil_rdata_t		r_q [$];

	// Fill pattern covers every word address bit
	function automatic logic [`WBAXIL_DW-1:0] read_word(input logic [`WBAXIL_AW-3:0] word);
		if (mem.exists(word))
			return mem[word];
		return {word[5:0], word} ^ 32'h5a3c_96e1;
	endfunction

	// Random ready, one chance in max_delay+1
	function automatic logic ready_roll();
		if (i_max_delay == 4'd0)
			return 1'b1;
		return ($urandom_range(i_max_delay, 0) == 0);
	endfunction

	initial
	begin
		o_awready = 1'b0;
		o_wready  = 1'b0;
		o_arready = 1'b0;
		o_bvalid  = 1'b0;
		o_bresp   = OKAY;
		o_rvalid  = 1'b0;
		o_r       = '0;
	end

	////////////////////////////////////////////////////////////
	// Channel handling
	////////////////////////////////////////////////////////////

	always @(posedge i_clk)
	begin : slave_step
		logic [`WBAXIL_AW-1:0]	addr;
		axil_wdata_t		wd;
		axil_rdata_t		rd;
		logic [`WBAXIL_DW-1:0]	word;
		if (!i_axi_reset_n)
		begin
			aw_q.delete();
			w_q.delete();
			b_q.delete();
			r_q.delete();
			o_awready <= 1'b0;
			o_wready  <= 1'b0;
			o_arready <= 1'b0;
			o_bvalid  <= 1'b0;
			o_rvalid  <= 1'b0;
		end
		else
		begin
			if (i_awvalid && o_awready)
				aw_q.push_back(i_aw.addr);
			if (i_wvalid && o_wready)
				w_q.push_back(i_w);
			// Write lands once both beats are in, top address bit is an error region
			if (aw_q.size() != 0 && w_q.size() != 0)
			begin
				addr = aw_q.pop_front();
				wd = w_q.pop_front();
				if (addr[`WBAXIL_AW-1])
					b_q.push_back(SLVERR);
				else
				begin
					word = read_word(addr[`WBAXIL_AW-1:2]);
					for (int i = 0; i < `WBAXIL_DW/8; i++)
						if (wd.strb[i])
							word[8*i +: 8] = wd.data[8*i +: 8];
					mem[addr[`WBAXIL_AW-1:2]] = word;
					b_q.push_back(OKAY);
				end
			end
			if (i_arvalid && o_arready)
			begin
				rd.data = i_ar.addr[`WBAXIL_AW-1] ? '0 : read_word(i_ar.addr[`WBAXIL_AW-1:2]);
				rd.resp = i_ar.addr[`WBAXIL_AW-1] ? SLVERR : OKAY;
				r_q.push_back(rd);
			end
			// Retire the presented responses
			if (o_bvalid && i_bready)
				b_q.delete(0);
			if (o_rvalid && i_rready)
				r_q.delete(0);
			// Hold only delays raising, a raised valid stays until taken
			if (!(o_bvalid && !i_bready))
			begin
				o_bvalid <= !i_hold && (b_q.size() != 0);
				if (b_q.size() != 0)
					o_bresp <= b_q[0];
			end
			if (!(o_rvalid && !i_rready))
			begin
				o_rvalid <= !i_hold && (r_q.size() != 0);
				if (r_q.size() != 0)
					o_r <= r_q[0];
			end
			o_awready <= ready_roll();
			o_wready  <= ready_roll();
			o_arready <= ready_roll();
		end
	end

endmodule

`default_nettype wire

// File: verif/wbaxil_tb.sv
`include "wbaxil_params.svh"

`default_nettype none
`timescale 1ns/1ps

module wbaxil_tb
	import wbaxil_pkg::*;
();

	localparam int LGD         = `WBAXIL_LGDEPTH;
	localparam int CYCLE_LIMIT = 3000;

	// One expected Wishbone return, in request order
	typedef struct packed
	{
		logic			we;
		axil_resp_e		resp;
		logic [`WBAXIL_DW-1:0]	data;
	} expect_t;

	logic			clk = 1'b0;
	logic			rst_n;
	logic			wb_cyc;
	logic			wb_stb;
	wb_req_t		wb_req;
	wire			wb_stall;
	wire			wb_ack;
	wire			wb_err;
	wire [`WBAXIL_DW-1:0]	wb_data;

	wire			axi_awvalid;
	wire			axi_awready;
	wire axil_addr_t	axi_aw;
	wire			axi_wvalid;
	wire			axi_wready;
	wire axil_wdata_t	axi_w;
	wire			axi_bvalid;
	wire			axi_bready;
	wire axil_resp_e	axi_bresp;
	wire			axi_arvalid;
	wire			axi_arready;
	wire axil_addr_t	axi_ar;
	wire			axi_rvalid;
	wire			axi_rready;
	wire axil_rdata_t	axi_r;
	wire [LGD-1:0]		awr_out;
	wire [LGD-1:0]		wr_out;
	wire [LGD-1:0]		rd_out;

	logic [3:0]		max_delay;
	logic			hold;

	// Shadow of slave memory and pending returns
	logic [`WBAXIL_DW-1:0]	shadow [logic [`WBAXIL_AW-3:0]];
	expect_t		exp_q [$];
	logic [LGD-1:0]		exp_awr = '0;
	logic [LGD-1:0]		exp_wr = '0;
	logic [LGD-1:0]		exp_rd = '0;
	int			errors = 0;
	int			checks = 0;
	// Ack pulses seen on the bus, stray ones included
	int			ack_count = 0;
	int			cycle_count = 0;

	wbaxil_top u_dut (
		.i_clk(clk), .i_axi_reset_n(rst_n),
		.i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_req(wb_req),
		.o_wb_stall(wb_stall), .o_wb_ack(wb_ack), .o_wb_err(wb_err), .o_wb_data(wb_data),
		.o_axi_awvalid(axi_awvalid), .i_axi_awready(axi_awready), .o_axi_aw(axi_aw),
		.o_axi_wvalid(axi_wvalid), .i_axi_wready(axi_wready), .o_axi_w(axi_w),
		.i_axi_bvalid(axi_bvalid), .o_axi_bready(axi_bready), .i_axi_bresp(axi_bresp),
		.o_axi_arvalid(axi_arvalid), .i_axi_arready(axi_arready), .o_axi_ar(axi_ar),
		.i_axi_rvalid(axi_rvalid), .o_axi_rready(axi_rready), .i_axi_r(axi_r),
		.o_awr_outstanding(awr_out), .o_wr_outstanding(wr_out), .o_rd_outstanding(rd_out)
	);

	axil_slave_model u_slave (
		.i_clk(clk), .i_axi_reset_n(rst_n), .i_max_delay(max_delay), .i_hold(hold),
		.i_awvalid(axi_awvalid), .o_awready(axi_awready), .i_aw(axi_aw),
		.i_wvalid(axi_wvalid), .o_wready(axi_wready), .i_w(axi_w),
		.o_bvalid(axi_bvalid), .i_bready(axi_bready), .o_bresp(axi_bresp),
		.i_arvalid(axi_arvalid), .o_arready(axi_arready), .i_ar(axi_ar),
		.o_rvalid(axi_rvalid), .i_rready(axi_rready), .o_r(axi_r)
	);

	always #10 clk = ~clk;

	// Run limit, tests need roughly 400 cycles
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT)
		begin
			$display("Timeout: no response arrived within %0d cycles", CYCLE_LIMIT);
			$display("Test FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_data(input logic [`WBAXIL_DW-1:0] got, input logic [`WBAXIL_DW-1:0] exp,
		input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_resp(input logic got_ack, input logic got_err, input logic exp_ack,
		input logic exp_err, input string what);
		checks++;
		if (got_ack !== exp_ack || got_err !== exp_err)
		begin
			errors++;
			$display("error at %0t ns: %s ack/err %b/%b expected %b/%b", $time, what,
				got_ack, got_err, exp_ack, exp_err);
		end
	endtask

	task automatic check_count(input logic [LGD-1:0] got, input logic [LGD-1:0] exp,
		input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Bus helpers
	////////////////////////////////////////////////////////////

	// Prior slave content, same fill pattern as the model
	function automatic logic [`WBAXIL_DW-1:0] expected_word(input logic [`WBAXIL_AW-3:0] word);
		if (shadow.exists(word))
			return shadow[word];
		return {word[5:0], word} ^ 32'h5a3c_96e1;
	endfunction

	function automatic wb_req_t make_req(input logic we, input logic [`WBAXIL_AW-1:0] addr,
		input logic [`WBAXIL_DW-1:0] data, input logic [`WBAXIL_DW/8-1:0] sel);
		wb_req_t req;
		req.we = we;
		req.addr = addr;
		req.data = data;
		req.sel = sel;
		return req;
	endfunction

	// Top address bit answers SLVERR and leaves memory alone
	task automatic record_expected(input wb_req_t req);
		expect_t		e;
		logic [`WBAXIL_DW-1:0]	word;
		e.we = req.we;
		e.resp = req.addr[`WBAXIL_AW-1] ? SLVERR : OKAY;
		word = expected_word(req.addr[`WBAXIL_AW-1:2]);
		if (req.we && e.resp == OKAY)
		begin
			for (int i = 0; i < `WBAXIL_DW/8; i++)
				if (req.sel[i])
					word[8*i +: 8] = req.data[8*i +: 8];
			shadow[req.addr[`WBAXIL_AW-1:2]] = word;
		end
		e.data = word;
		exp_q.push_back(e);
	endtask

	// One clock, then count model and return checks
	task automatic step();
		logic		aw_hs;
		logic		w_hs;
		logic		b_hs;
		logic		ar_hs;
		logic		r_hs;
		expect_t	e;
		aw_hs = axi_awvalid && axi_awready;
		w_hs  = axi_wvalid && axi_wready;
		b_hs  = axi_bvalid && axi_bready;
		ar_hs = axi_arvalid && axi_arready;
		r_hs  = axi_rvalid && axi_rready;
		@(posedge clk);
		#1;
		// One B retires both the AW and the W
		exp_awr = exp_awr + LGD'(aw_hs) - LGD'(b_hs);
		exp_wr  = exp_wr + LGD'(w_hs) - LGD'(b_hs);
		exp_rd  = exp_rd + LGD'(ar_hs) - LGD'(r_hs);
		check_count(awr_out, exp_awr, "write address count");
		check_count(wr_out, exp_wr, "write data count");
		check_count(rd_out, exp_rd, "read count");
		if (wb_ack)
			ack_count++;
		if (wb_ack || wb_err)
		begin
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("Response at %0t ns arrived with no request pending", $time);
			end
			else
			begin
				e = exp_q.pop_front();
				check_resp(wb_ack, wb_err, !e.resp[1], e.resp[1], "response");
				if (!e.we && e.resp == OKAY)
					check_data(wb_data, e.data, "read data");
			end
		end
	endtask

	// Present on stb until stall is low, then one accepting edge
	task automatic issue(input wb_req_t req);
		wb_stb = 1'b1;
		wb_req = req;
		while (wb_stall)
			step();
		record_expected(req);
		step();
		wb_stb = 1'b0;
	endtask

	// Extra cycles catch a stray return
	task automatic drain();
		while (exp_q.size() != 0)
			step();
		repeat (3)
			step();
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic test_reset_idle();
		repeat (10)
		begin
			check_resp(wb_ack, wb_err, 1'b0, 1'b0, "idle response");
			check_count(LGD'(wb_stall), '0, "idle stall");
			check_count(awr_out | wr_out | rd_out, '0, "idle counts");
			step();
		end
	endtask

	task automatic test_write_read();
		issue(make_req(1'b1, 28'h000_0100, $urandom(), 4'hf));
		issue(make_req(1'b0, 28'h000_0100, '0, 4'hf));
		// Partial selects keep the other bytes
		issue(make_req(1'b1, 28'h000_0100, $urandom(), 4'b0101));
		issue(make_req(1'b0, 28'h000_0100, '0, 4'hf));
		issue(make_req(1'b1, 28'h000_0204, $urandom(), 4'b1000));
		issue(make_req(1'b0, 28'h000_0204, '0, 4'hf));
		drain();
	endtask

	task automatic test_error_address();
		issue(make_req(1'b1, 28'h800_0040, $urandom(), 4'hf));
		issue(make_req(1'b0, 28'h800_0040, '0, 4'hf));
		issue(make_req(1'b0, 28'h000_0040, '0, 4'hf));
		drain();
	endtask

	task automatic test_pipelined_mix();
		int		start;
		wb_req_t	req;
		max_delay = 4'd3;
		start = ack_count;
		// Eight words so reads often hit earlier writes
		for (int n = 0; n < 40; n++)
		begin
			req.we = 1'($urandom_range(1, 0));
			req.addr = {16'h0, 7'h12, 3'($urandom_range(7, 0)), 2'b00};
			req.data = $urandom();
			req.sel = 4'($urandom_range(15, 0));
			issue(req);
		end
		drain();
		check_data(ack_count - start, 32'd40, "acks for 40 requests");
		max_delay = 4'd0;
	endtask

	task automatic test_backpressure();
		wb_req_t	extra;
		hold = 1'b1;
		issue(make_req(1'b1, 28'h000_0300, $urandom(), 4'hf));
		issue(make_req(1'b0, 28'h000_0300, '0, 4'hf));
		issue(make_req(1'b1, 28'h000_0304, $urandom(), 4'hf));
		issue(make_req(1'b0, 28'h000_0304, '0, 4'hf));
		// Fifth waits on the full tag queue
		extra = make_req(1'b0, 28'h000_0304, '0, 4'hf);
		wb_stb = 1'b1;
		wb_req = extra;
		repeat (4)
		begin
			check_count(LGD'(wb_stall), LGD'(1), "stall with four in flight");
			step();
		end
		check_count(awr_out, LGD'(2), "held write addresses");
		check_count(wr_out, LGD'(2), "held write data");
		check_count(rd_out, LGD'(2), "held reads");
		hold = 1'b0;
		issue(extra);
		drain();
		check_count(awr_out | wr_out | rd_out, '0, "counts after release");
	endtask

	initial
	begin
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_req = '0;
		max_delay = 4'd0;
		hold = 1'b0;
		void'($urandom(57));
		repeat (5)
			@(posedge clk);
		#1;
		rst_n = 1'b1;
		wb_cyc = 1'b1;
		test_reset_idle();
		test_write_read();
		test_error_address();
		test_pipelined_mix();
		test_backpressure();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
